/* qspi_opcode_pkg.sv */
package qspi_opcode_pkg;

    // Flash opcodes known to the controller
    typedef enum logic [7:0] {
        // Fast reads, 3 or 4 address bytes by mode
        OP_READ_FAST     = 8'h0B,
        OP_READ_QUAD_OUT = 8'h6B,
        OP_READ_QUAD_IO  = 8'hEB,
        // Fast reads, always 4 address bytes
        OP_READ_FAST4    = 8'h0C,
        OP_READ_QUAD_OUT4 = 8'h6C,
        OP_READ_QUAD_IO4 = 8'hEC,
        // Page programs
        OP_PROG_PAGE     = 8'h02,
        OP_PROG_QUAD     = 8'h32,
        OP_PROG_QUAD_EXT = 8'h12,
        // OTP array access
        OP_READ_OTP      = 8'h4B,
        OP_PROG_OTP      = 8'h22,
        // Erase
        OP_ERASE_SUB     = 8'h20,
        OP_ERASE_SECT    = 8'hD8,
        // Lock register, addressed
        OP_READ_LOCK     = 8'hE8,
        OP_WRITE_LOCK    = 8'hE5,
        // Address mode switch
        OP_EN4BYTEA      = 8'hB7,
        OP_EX4BYTEA      = 8'hE9,
        // Plain commands
        OP_WREN          = 8'h06,
        OP_RDSR          = 8'h05
    } flash_opcode_t;

    // Address lengths in bytes
    localparam logic [2:0] ADDR_BYTES_SHORT = 3'd3;
    localparam logic [2:0] ADDR_BYTES_LONG  = 3'd4;

endpackage

/* qspi_ctrl_pkg.sv */
package qspi_ctrl_pkg;

    typedef logic [7:0] byte_t;

    // Address byte count, up to 4
    typedef logic [2:0] addr_cnt_t;

    // Dummy clock count
    typedef logic [3:0] dummy_cnt_t;

    // One bit per data lane, lane 0 in bit 0
    typedef logic [3:0] lanes_t;

    typedef enum logic [2:0] {
        IDLE, COMMAND, ADDRESS, WRITE, DUMMY, READ_WAIT, READ, FINISH
    } seq_state_t;

    // Pulled-up bus, outputs released
    localparam lanes_t LANES_IDLE = 4'b1111;

    // Serial mode: only lane 0 is an output
    localparam lanes_t SERIAL_DT = 4'b1110;

endpackage

/* qspi_phy_if.sv */
`timescale 1ns/100ps

interface qspi_phy_if;
    import qspi_ctrl_pkg::*;

    // Byte offered to the PHY
    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;
    // Byte goes out on the lanes, otherwise the flash drives
    logic  tx_drive;
    // One floating clock instead of a byte
    logic  dummy;

    // Byte captured from the flash
    byte_t rx_data;
    logic  rx_valid;

    modport seq (
        output tx_data, tx_valid, tx_drive, dummy,
        input  tx_ready, rx_data, rx_valid
    );

    modport phy (
        input  tx_data, tx_valid, tx_drive, dummy,
        output tx_ready, rx_data, rx_valid
    );

endinterface

/* qspi_phy.sv */
`timescale 1ns/100ps

module qspi_phy #(
    parameter bit MODE_QIO = 1'b1
) (
    input  logic                  clk,
    input  logic                  reset,
    qspi_phy_if.phy               phy,
    input  qspi_ctrl_pkg::lanes_t di,
    output qspi_ctrl_pkg::lanes_t dout,
    output qspi_ctrl_pkg::lanes_t dt,
    output logic                  ncs
);
    import qspi_ctrl_pkg::*;

    // Bits moved per clock and slots per byte
    localparam int         STEP      = MODE_QIO ? 4 : 1;
    localparam logic [2:0] LAST_SLOT = MODE_QIO ? 3'd1 : 3'd7;
    localparam lanes_t     DRIVE_DT  = MODE_QIO ? 4'b0000 : SERIAL_DT;

    logic       active;
    logic [2:0] slot;
    logic       slot_dummy;
    logic       driving;
    logic       last_slot;
    logic       take;
    byte_t      tx_shift;
    byte_t      rx_shift;
    byte_t      rx_next;

    // Top bits of a byte as lane values
    function automatic lanes_t lane_bits(byte_t b);
        return MODE_QIO ? b[7:4] : {3'b111, b[7]};
    endfunction

    assign last_slot = (slot == LAST_SLOT);

    // Free when idle, at a byte boundary, or on any dummy clock
    assign phy.tx_ready = !active || last_slot || slot_dummy;
    assign take         = phy.tx_valid && phy.tx_ready;

    // Quad: nibble from all lanes. Serial: one bit from lane 1
    assign rx_next = MODE_QIO ? {rx_shift[3:0], di} : {rx_shift[6:0], di[1]};

    always_ff @(posedge clk) begin
        if (reset) begin
            active       <= 1'b0;
            slot         <= '0;
            slot_dummy   <= 1'b0;
            driving      <= 1'b0;
            ncs          <= 1'b1;
            dt           <= LANES_IDLE;
            dout         <= LANES_IDLE;
            phy.rx_valid <= 1'b0;
        end else begin
            // Read byte complete at the end of its last slot
            phy.rx_valid <= active && !driving && !slot_dummy && last_slot;

            if (take) begin
                active     <= 1'b1;
                ncs        <= 1'b0;
                slot       <= '0;
                slot_dummy <= phy.dummy;
                driving    <= phy.tx_drive && !phy.dummy;
                if (phy.dummy || !phy.tx_drive) begin
                    // Flash owns the lanes
                    dout <= LANES_IDLE;
                    dt   <= LANES_IDLE;
                end else begin
                    dout <= lane_bits(phy.tx_data);
                    dt   <= DRIVE_DT;
                end
            end else if (active && !phy.tx_ready) begin
                // Mid byte, next slot
                slot <= slot + 3'd1;
                if (driving) begin
                    dout <= lane_bits(tx_shift);
                end
            end else if (active) begin
                // Boundary with nothing offered, end of frame
                active     <= 1'b0;
                ncs        <= 1'b1;
                slot_dummy <= 1'b0;
                driving    <= 1'b0;
                dt         <= LANES_IDLE;
                dout       <= LANES_IDLE;
            end
        end
    end

    // Data path shift registers
    always_ff @(posedge clk) begin
        if (take) begin
            tx_shift <= phy.tx_data << STEP;
        end else begin
            tx_shift <= tx_shift << STEP;
        end

        // Sample at the edge that closes each read slot
        if (active && !driving && !slot_dummy) begin
            rx_shift <= rx_next;
            if (last_slot) begin
                phy.rx_data <= rx_next;
            end
        end
    end

endmodule

/* qspi_cmd_decode.sv */
`timescale 1ns/100ps

module qspi_cmd_decode #(
    parameter bit ADDR4_DEFAULT = 1'b0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  qspi_ctrl_pkg::byte_t     opcode,
    input  logic                     opcode_take,
    output qspi_ctrl_pkg::addr_cnt_t addr_bytes,
    output logic                     uses_dummy,
    output logic                     addr4_mode
);
    import qspi_opcode_pkg::*;

    flash_opcode_t op;
    logic          addr_3or4;
    logic          addr_4;

    assign op = flash_opcode_t'(opcode);

    // Address class and dummy need per opcode
    always_comb begin
        addr_3or4  = 1'b0;
        addr_4     = 1'b0;
        uses_dummy = 1'b0;
        case (op)
            OP_READ_FAST, OP_READ_QUAD_OUT, OP_READ_QUAD_IO: begin
                addr_3or4  = 1'b1;
                uses_dummy = 1'b1;
            end
            OP_READ_FAST4, OP_READ_QUAD_OUT4, OP_READ_QUAD_IO4: begin
                addr_4     = 1'b1;
                uses_dummy = 1'b1;
            end
            // OTP read goes without dummy clocks here
            OP_PROG_PAGE, OP_PROG_QUAD, OP_PROG_QUAD_EXT,
            OP_READ_OTP, OP_PROG_OTP, OP_ERASE_SUB, OP_ERASE_SECT,
            OP_READ_LOCK, OP_WRITE_LOCK: begin
                addr_3or4 = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // 4-byte address mode, toggled by the mode opcodes
    always_ff @(posedge clk) begin
        if (reset) begin
            addr4_mode <= ADDR4_DEFAULT;
        end else if (opcode_take) begin
            if (op == OP_EN4BYTEA) begin
                addr4_mode <= 1'b1;
            end else if (op == OP_EX4BYTEA) begin
                addr4_mode <= 1'b0;
            end
        end
    end

    // Address length after the mode is applied
    always_comb begin
        if (addr_4 || (addr_3or4 && addr4_mode)) begin
            addr_bytes = ADDR_BYTES_LONG;
        end else if (addr_3or4) begin
            addr_bytes = ADDR_BYTES_SHORT;
        end else begin
            addr_bytes = 3'd0;
        end
    end

endmodule

/* qspi_seq.sv */
`timescale 1ns/100ps

module qspi_seq #(
    parameter bit                        MODE_QIO     = 1'b1,
    parameter qspi_ctrl_pkg::dummy_cnt_t DUMMY_CYCLES = 4'd10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  qspi_ctrl_pkg::byte_t     cmd_data,
    input  logic                     cmd_valid,
    input  logic                     cmd_last,
    output logic                     cmd_ready,
    output qspi_ctrl_pkg::byte_t     out_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     out_last,
    qspi_phy_if.seq                  phy,
    output qspi_ctrl_pkg::byte_t     opcode,
    output logic                     opcode_take,
    input  qspi_ctrl_pkg::addr_cnt_t addr_bytes,
    input  logic                     uses_dummy
);
    import qspi_ctrl_pkg::*;

    // Don't-care byte offered in dummy and read slots
    localparam byte_t FILL_BYTE = MODE_QIO ? 8'hFF : 8'h00;

    seq_state_t state;
    seq_state_t after_addr;
    byte_t      read_left;
    byte_t      req_left;
    addr_cnt_t  addr_left;
    dummy_cnt_t dummy_left;
    logic       with_dummy;
    logic       short_cmd;
    logic       rx_drop;

    // Opcode goes to the decoder straight from the stream
    assign opcode      = cmd_data;
    assign opcode_take = (state == COMMAND) && cmd_valid;

    // Opcode marked last but address still expected
    assign short_cmd = cmd_last && (addr_bytes != 3'd0);

    always_comb begin
        case (state)
            IDLE, COMMAND:  cmd_ready = 1'b1;
            ADDRESS, WRITE: cmd_ready = phy.tx_ready;
            default:        cmd_ready = 1'b0;
        endcase
    end

    // What the PHY sees in each phase
    always_comb begin
        phy.tx_data  = FILL_BYTE;
        phy.tx_valid = 1'b0;
        phy.tx_drive = 1'b0;
        phy.dummy    = 1'b0;
        case (state)
            COMMAND: begin
                phy.tx_data  = cmd_data;
                phy.tx_valid = cmd_valid && !short_cmd;
                phy.tx_drive = 1'b1;
            end
            ADDRESS, WRITE: begin
                phy.tx_data  = cmd_data;
                phy.tx_valid = cmd_valid;
                phy.tx_drive = 1'b1;
            end
            DUMMY: begin
                phy.tx_valid = 1'b1;
                phy.dummy    = 1'b1;
            end
            // One request per read byte, lanes released
            READ: phy.tx_valid = 1'b1;
            default: begin
            end
        endcase
    end

    // Read bytes go out only while a read is live
    assign out_data  = phy.rx_data;
    assign out_valid = phy.rx_valid && ((state == READ) || (state == READ_WAIT));
    assign out_last  = (read_left == 8'd1);
    assign rx_drop   = out_valid && !out_ready;

    // Phase after the final address byte
    always_comb begin
        if (with_dummy && (DUMMY_CYCLES != 4'd0)) begin
            after_addr = DUMMY;
        end else if (read_left != 8'd0) begin
            after_addr = READ;
        end else begin
            after_addr = FINISH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            read_left  <= '0;
            req_left   <= '0;
            addr_left  <= '0;
            dummy_left <= '0;
            with_dummy <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                read_left <= read_left - 8'd1;
            end
            case (state)
                IDLE: begin
                    // Byte 0 is the read count
                    if (cmd_valid && !cmd_last) begin
                        read_left <= cmd_data;
                        req_left  <= cmd_data;
                        state     <= COMMAND;
                    end
                end
                COMMAND: begin
                    if (cmd_valid) begin
                        addr_left  <= addr_bytes;
                        with_dummy <= uses_dummy;
                        dummy_left <= DUMMY_CYCLES;
                        if (short_cmd) begin
                            state <= FINISH;
                        end else if (cmd_last) begin
                            state <= (read_left != 8'd0) ? READ : FINISH;
                        end else begin
                            state <= (addr_bytes != 3'd0) ? ADDRESS : WRITE;
                        end
                    end
                end
                ADDRESS: begin
                    if (phy.tx_ready) begin
                        addr_left <= addr_left - 3'd1;
                        // Stream ran dry or ended early
                        if (!cmd_valid) begin
                            state <= FINISH;
                        end else if (addr_left == 3'd1) begin
                            state <= cmd_last ? after_addr : WRITE;
                        end else if (cmd_last) begin
                            state <= FINISH;
                        end
                    end
                end
                WRITE: begin
                    if (phy.tx_ready) begin
                        if (!cmd_valid) begin
                            state <= FINISH;
                        end else if (cmd_last) begin
                            state <= (read_left != 8'd0) ? READ : FINISH;
                        end
                    end
                end
                DUMMY: begin
                    if (phy.tx_ready) begin
                        dummy_left <= dummy_left - 4'd1;
                        if (dummy_left == 4'd1) begin
                            state <= (read_left != 8'd0) ? READ : FINISH;
                        end
                    end
                end
                READ: begin
                    if (phy.tx_ready) begin
                        req_left <= req_left - 8'd1;
                    end
                    // Consumer stalled, drop the rest
                    if (rx_drop) begin
                        state <= FINISH;
                    end else if (phy.tx_ready && (req_left == 8'd1)) begin
                        state <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    if (rx_drop || (out_valid && out_last)) begin
                        state <= FINISH;
                    end
                end
                // PHY closes the frame at its next boundary
                FINISH: begin
                    if (phy.tx_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* qspi_flash_ctrl.sv */
`timescale 1ns/100ps

module qspi_flash_ctrl #(
    parameter bit                        MODE_QIO      = 1'b1,
    parameter qspi_ctrl_pkg::dummy_cnt_t DUMMY_CYCLES  = 4'd10,
    parameter bit                        ADDR4_DEFAULT = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset,
    // Flash pins
    input  qspi_ctrl_pkg::lanes_t di,
    output qspi_ctrl_pkg::lanes_t dout,
    output qspi_ctrl_pkg::lanes_t dt,
    output logic                  ncs,
    // Command stream: count, opcode, address, write data
    input  qspi_ctrl_pkg::byte_t  cmd_data,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic                  cmd_last,
    // Read data stream
    output qspi_ctrl_pkg::byte_t  out_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  out_last
);
    import qspi_ctrl_pkg::*;

    byte_t     opcode;
    logic      opcode_take;
    addr_cnt_t addr_bytes;
    logic      uses_dummy;

    qspi_phy_if phy_if ();

    qspi_phy #(
        .MODE_QIO (MODE_QIO)
    ) phy_i (
        .clk   (clk),
        .reset (reset),
        .phy   (phy_if.phy),
        .di    (di),
        .dout  (dout),
        .dt    (dt),
        .ncs   (ncs)
    );

    qspi_cmd_decode #(
        .ADDR4_DEFAULT (ADDR4_DEFAULT)
    ) decode_i (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .opcode_take (opcode_take),
        .addr_bytes  (addr_bytes),
        .uses_dummy  (uses_dummy),
        .addr4_mode  ()
    );

    qspi_seq #(
        .MODE_QIO     (MODE_QIO),
        .DUMMY_CYCLES (DUMMY_CYCLES)
    ) seq_i (
        .clk         (clk),
        .reset       (reset),
        .cmd_data    (cmd_data),
        .cmd_valid   (cmd_valid),
        .cmd_last    (cmd_last),
        .cmd_ready   (cmd_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_last    (out_last),
        .phy         (phy_if.seq),
        .opcode      (opcode),
        .opcode_take (opcode_take),
        .addr_bytes  (addr_bytes),
        .uses_dummy  (uses_dummy)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* tb_flash_model.sv */
`timescale 1ns/100ps

module tb_flash_model #(
    parameter bit MODE_QIO     = 1'b1,
    parameter int DUMMY_CYCLES = 10
) (
    input  logic                  clk,
    input  logic                  ncs,
    input  qspi_ctrl_pkg::lanes_t dout,
    output qspi_ctrl_pkg::lanes_t di = 4'b1111
);
    import qspi_opcode_pkg::*;
    import qspi_ctrl_pkg::*;

    localparam int SLOTS = MODE_QIO ? 2 : 8;
    localparam int NEVER = 1 << 30;

    // Bytes seen on the lanes in the current frame
    byte_t cap_bytes [16];
    int    cap_count = 0;

    int    slot_n = 0;
    int    addr_n = 0;
    int    drive_end = NEVER;
    int    read_start = NEVER;
    logic  is_read = 1'b0;
    logic  addr4 = 1'b0;
    byte_t shift = '0;
    byte_t last_addr = '0;

    // Address length, dummy need and direction per opcode
    task automatic classify(input byte_t op);
        logic dummy;
        dummy = 1'b0;
        addr_n = 0;
        is_read = 1'b0;
        case (flash_opcode_t'(op))
            OP_READ_FAST, OP_READ_QUAD_OUT, OP_READ_QUAD_IO: begin
                addr_n = addr4 ? 4 : 3;
                dummy = 1'b1;
                is_read = 1'b1;
            end
            OP_READ_FAST4, OP_READ_QUAD_OUT4, OP_READ_QUAD_IO4: begin
                addr_n = 4;
                dummy = 1'b1;
                is_read = 1'b1;
            end
            OP_READ_OTP, OP_READ_LOCK: begin
                addr_n = addr4 ? 4 : 3;
                is_read = 1'b1;
            end
            OP_PROG_PAGE, OP_PROG_QUAD, OP_PROG_QUAD_EXT, OP_PROG_OTP,
            OP_ERASE_SUB, OP_ERASE_SECT, OP_WRITE_LOCK: begin
                addr_n = addr4 ? 4 : 3;
            end
            OP_RDSR: is_read = 1'b1;
            OP_EN4BYTEA: addr4 = 1'b1;
            OP_EX4BYTEA: addr4 = 1'b0;
            default: begin
            end
        endcase
        if (is_read) begin
            drive_end = SLOTS * (1 + addr_n);
            read_start = drive_end + (dummy ? DUMMY_CYCLES : 0);
        end
    endtask

    // Lane values the flash presents in slot n
    function automatic lanes_t read_lanes(input int n);
        int    k;
        int    off;
        byte_t b;
        if (!is_read || n < read_start) begin
            return LANES_IDLE;
        end
        k = (n - read_start) / SLOTS;
        off = (n - read_start) % SLOTS;
        b = (addr_n != 0) ? last_addr + byte_t'(k) : 8'hA5 + byte_t'(k);
        if (MODE_QIO) begin
            return (off == 0) ? b[7:4] : b[3:0];
        end
        // Serial data comes back on lane 1
        return {2'b11, b[7 - off], 1'b1};
    endfunction

    always @(posedge clk) begin
        if (ncs) begin
            slot_n = 0;
            is_read = 1'b0;
            drive_end = NEVER;
            read_start = NEVER;
            di <= LANES_IDLE;
        end else begin
            if (slot_n == 0) begin
                cap_count = 0;
            end
            if (slot_n < drive_end) begin
                shift = MODE_QIO ? {shift[3:0], dout} : {shift[6:0], dout[0]};
                if ((slot_n % SLOTS) == SLOTS - 1) begin
                    if (cap_count < 16) begin
                        cap_bytes[cap_count] = shift;
                    end
                    cap_count++;
                    if (cap_count == 1) begin
                        classify(shift);
                    end else if (cap_count == 1 + addr_n) begin
                        last_addr = shift;
                    end
                end
            end
            slot_n++;
            di <= read_lanes(slot_n);
        end
    end

endmodule

/* qspi_flash_ctrl_tb.sv */
`timescale 1ns/100ps

module qspi_flash_ctrl_tb #(
    parameter bit MODE_QIO = 1'b1
);
    import qspi_ctrl_pkg::*;

    localparam int ROWS  = 11;
    localparam int DUMMY = 10;

    logic   clk;
    logic   reset;
    lanes_t di;
    lanes_t dout;
    lanes_t dt;
    logic   ncs;
    byte_t  cmd_data = '0;
    logic   cmd_valid = 1'b0;
    logic   cmd_last = 1'b0;
    logic   cmd_ready;
    byte_t  out_data;
    logic   out_valid;
    logic   out_ready = 1'b1;
    logic   out_last;

    // Command table, bytes left aligned in 64-bit words
    string       row_name [ROWS];
    logic [63:0] row_cmd [ROWS];
    int          row_len [ROWS];
    int          row_gap [ROWS];
    logic [63:0] row_cap [ROWS];
    int          row_cap_len [ROWS];
    logic [63:0] row_rd [ROWS];
    int          row_rd_len [ROWS];
    logic        row_abort [ROWS];
    // 0 ready, 1 random, 2 held low
    int          row_rmode [ROWS];

    int    errors = 0;
    int    rows_ok = 0;
    int    ready_mode = 0;
    int    seed = 32'hb33d2a19;
    int    frames_done = 0;
    int    valid_pulses = 0;
    logic  ncs_q = 1'b1;
    byte_t got_data[$];
    logic  got_last[$];

    tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(3)) clock_i (.clk(clk), .reset(reset));

    qspi_flash_ctrl #(
        .MODE_QIO     (MODE_QIO),
        .DUMMY_CYCLES (4'(DUMMY))
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .di        (di),
        .dout      (dout),
        .dt        (dt),
        .ncs       (ncs),
        .cmd_data  (cmd_data),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_last  (cmd_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last)
    );

    tb_flash_model #(.MODE_QIO(MODE_QIO), .DUMMY_CYCLES(DUMMY)) model_i (
        .clk  (clk),
        .ncs  (ncs),
        .dout (dout),
        .di   (di)
    );

    // Read stream and frame monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                valid_pulses++;
            end
            if (out_valid && out_ready) begin
                got_data.push_back(out_data);
                got_last.push_back(out_last);
            end
            if (ncs && !ncs_q) begin
                frames_done <= frames_done + 1;
            end
        end
        ncs_q <= ncs;
    end

    // Consumer ready pattern
    always @(posedge clk) begin
        int rnd;
        rnd = $random(seed);
        case (ready_mode)
            1: out_ready <= rnd[0];
            2: out_ready <= 1'b0;
            default: out_ready <= 1'b1;
        endcase
    end

    function automatic byte_t byte_at(input logic [63:0] v, input int i);
        return v[63 - 8 * i -: 8];
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_lanes(input string name, input lanes_t got, input lanes_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic add_row(input int r, input string name, input logic [63:0] cmd,
                           input int len, input int gap, input logic [63:0] cap,
                           input int cap_len, input logic [63:0] rd, input int rd_len,
                           input logic abort, input int rmode);
        row_name[r] = name;
        row_cmd[r] = cmd;
        row_len[r] = len;
        row_gap[r] = gap;
        row_cap[r] = cap;
        row_cap_len[r] = cap_len;
        row_rd[r] = rd;
        row_rd_len[r] = rd_len;
        row_abort[r] = abort;
        row_rmode[r] = rmode;
    endtask

    // Read data follows last address byte plus k, or 0xA5 plus k
    task automatic build_table();
        add_row(0, "fast read, 3-byte address", 64'h040B123456000000, 5, -1,
                64'h0B12345600000000, 4, 64'h5657585900000000, 4, 1'b0, 0);
        add_row(1, "write enable", 64'h0006000000000000, 2, -1,
                64'h0600000000000000, 1, 64'h0, 0, 1'b0, 1);
        add_row(2, "page program", 64'h0002102030C33C00, 7, -1,
                64'h02102030C33C0000, 6, 64'h0, 0, 1'b0, 1);
        add_row(3, "enter 4-byte mode", 64'h00B7000000000000, 2, -1,
                64'hB700000000000000, 1, 64'h0, 0, 1'b0, 1);
        add_row(4, "fast read, 4-byte address", 64'h040B010203400000, 6, -1,
                64'h0B01020340000000, 5, 64'h4041424300000000, 4, 1'b0, 0);
        add_row(5, "exit 4-byte mode", 64'h00E9000000000000, 2, -1,
                64'hE900000000000000, 1, 64'h0, 0, 1'b0, 1);
        add_row(6, "fast read after exit", 64'h040B0A0B0C000000, 5, -1,
                64'h0B0A0B0C00000000, 4, 64'h0C0D0E0F00000000, 4, 1'b0, 0);
        add_row(7, "address gap abort", 64'h040B212223000000, 5, 4,
                64'h0B21220000000000, 3, 64'h0, 0, 1'b1, 0);
        add_row(8, "fast read after abort", 64'h020B313233000000, 5, -1,
                64'h0B31323300000000, 4, 64'h3334000000000000, 2, 1'b0, 0);
        add_row(9, "read stall abort", 64'h040B414243000000, 5, -1,
                64'h0B41424300000000, 4, 64'h0, 0, 1'b1, 2);
        add_row(10, "status read", 64'h0205000000000000, 2, -1,
                64'h0500000000000000, 1, 64'hA5A6000000000000, 2, 1'b0, 0);
    endtask

    task automatic run_row(input int r);
        int   idx;
        int   sent;
        int   start_frames;
        int   start_errors;
        int   requested;
        int   k;
        logic aborted;
        start_errors = errors;
        requested = int'(byte_at(row_cmd[r], 0));
        sent = (row_gap[r] >= 0) ? row_gap[r] : row_len[r];
        got_data.delete();
        got_last.delete();
        valid_pulses = 0;
        start_frames = frames_done;
        ready_mode = row_rmode[r];

        idx = 0;
        cmd_data <= byte_at(row_cmd[r], 0);
        cmd_valid <= 1'b1;
        cmd_last <= (row_len[r] == 1);
        while (idx < sent) begin
            @(posedge clk);
            if (cmd_valid && cmd_ready) begin
                idx++;
                if (idx < sent) begin
                    cmd_data <= byte_at(row_cmd[r], idx);
                    cmd_last <= (idx == row_len[r] - 1);
                end else begin
                    // Gap rows stop here and leave the stream dry
                    cmd_valid <= 1'b0;
                    cmd_last <= 1'b0;
                end
            end
        end

        // Frame closed, then sequencer back in IDLE
        while (frames_done == start_frames) begin
            @(posedge clk);
        end
        do begin
            @(posedge clk);
        end while (!cmd_ready);
        ready_mode = 0;

        check_byte("captured byte count", byte_t'(model_i.cap_count),
                   byte_t'(row_cap_len[r]));
        for (k = 0; k < row_cap_len[r] && k < model_i.cap_count; k++) begin
            check_byte($sformatf("captured byte %0d", k), model_i.cap_bytes[k],
                       byte_at(row_cap[r], k));
        end
        check_byte("out_data count", byte_t'(got_data.size()), byte_t'(row_rd_len[r]));
        for (k = 0; k < row_rd_len[r] && k < got_data.size(); k++) begin
            check_byte($sformatf("out_data %0d", k), got_data[k], byte_at(row_rd[r], k));
            check_flag($sformatf("out_last %0d", k), got_last[k], k == row_rd_len[r] - 1);
        end
        if (requested == 0) begin
            check_byte("out_valid pulses", byte_t'(valid_pulses), 8'h00);
        end
        aborted = (got_data.size() < requested) || (model_i.cap_count != row_len[r] - 1);
        check_flag("abort", aborted, row_abort[r]);
        check_flag("ncs", ncs, 1'b1);

        if (errors == start_errors) begin
            rows_ok++;
            $display("test %0d (%s): ok", r, row_name[r]);
        end else begin
            $display("test %0d (%s): FAILED with %0d errors", r, row_name[r],
                     errors - start_errors);
        end
    endtask

    initial begin
        int limit;
        int r;
        build_table();

        // Every command and read byte at serial speed, doubled
        limit = 0;
        for (r = 0; r < ROWS; r++) begin
            limit += (row_len[r] + int'(byte_at(row_cmd[r], 0))) * 8 * 10 * 2;
        end
        fork
            begin
                #(limit);
                $display("watchdog expired after %0d ns, run did not finish", limit);
                $display("tests failed");
                $finish;
            end
        join_none

        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        check_flag("ncs after reset", ncs, 1'b1);
        check_lanes("dt after reset", dt, LANES_IDLE);
        check_lanes("dout after reset", dout, LANES_IDLE);
        check_flag("cmd_ready after reset", cmd_ready, 1'b1);
        check_flag("out_valid after reset", out_valid, 1'b0);

        for (r = 0; r < ROWS; r++) begin
            run_row(r);
        end

        $display("%0d of %0d rows ok, %0d errors, MODE_QIO=%0d", rows_ok, ROWS, errors,
                 MODE_QIO);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* qspi_flash_ctrl.f */
qspi_opcode_pkg.sv
qspi_ctrl_pkg.sv
qspi_phy_if.sv
qspi_phy.sv
qspi_cmd_decode.sv
qspi_seq.sv
qspi_flash_ctrl.sv
tb_clock_gen.sv
tb_flash_model.sv
qspi_flash_ctrl_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench once per lane mode with Verilator

cd "$(dirname "$0")" || exit 1

status=0
for mode in 0 1; do
    obj="obj_dir_qio${mode}"
    log="sim_qio${mode}.log"

    verilator --binary --timing -Wno-fatal --top-module qspi_flash_ctrl_tb \
        -GMODE_QIO=${mode} --Mdir "${obj}" -f qspi_flash_ctrl.f
    if [ $? -ne 0 ]; then
        echo "build failed for MODE_QIO=${mode}"
        exit 1
    fi

    "./${obj}/Vqspi_flash_ctrl_tb" > "${log}" 2>&1
    if [ $? -ne 0 ]; then
        echo "simulation exited with an error for MODE_QIO=${mode}"
        status=1
    fi
    cat "${log}"

    if grep -q "^all tests passed$" "${log}"; then
        echo "MODE_QIO=${mode}: pass"
    else
        echo "MODE_QIO=${mode}: fail"
        status=1
    fi
done

exit ${status}
